//--- verilog/conv_acc_pkg.sv
package conv_acc_pkg;

    // --------------------------------------------------
    // sizes
    // --------------------------------------------------

    // pixels carried by one input beat
    localparam int PIX        = 2;
    // output-channel lanes per pixel
    localparam int LANES      = 4;

    // raw product width from the multiplier array
    localparam int PROD_W     = 19;
    // accumulated half width
    localparam int ACC_W      = 24;

    // kernel tap counter width
    localparam int K_W        = 4;

    // output buffer
    localparam int DEPTH_W    = 6;
    localparam int OBUF_DEPTH = 64;

    // --------------------------------------------------
    // data words
    // --------------------------------------------------

    // two products per lane, hi in the upper bits
    typedef struct packed {
        logic signed [PROD_W-1:0] hi;
        logic signed [PROD_W-1:0] lo;
    } prod_pair_t;

    typedef struct packed {
        logic signed [ACC_W-1:0] hi;
        logic signed [ACC_W-1:0] lo;
    } acc_pair_t;

    // one input beat, lane index = pixel * LANES + lane
    typedef prod_pair_t [PIX*LANES-1:0] beat_t;

    // group sum, also the buffer word
    typedef acc_pair_t [PIX*LANES-1:0] macc_t;

    // --------------------------------------------------
    // control
    // --------------------------------------------------

    // layer shape, held for a whole line
    typedef struct packed {
        logic [K_W-1:0]     kx;
        logic [DEPTH_W-1:0] co_group;
        logic [DEPTH_W-1:0] wo_group;
    } conv_cfg_t;

    // per-cycle buffer controls from the tap counter
    typedef struct packed {
        logic               group_end;
        logic               rd_en;
        logic [DEPTH_W-1:0] addr;
        logic               first_row;
    } tap_ctl_t;

endpackage

//--- verilog/tap_counter.sv
`timescale 1ns/1ps

module tap_counter
    import conv_acc_pkg::*;
(
    input  logic      I_clk,
    input  logic      reset_i,
    input  conv_cfg_t cfg_i,
    input  logic      compute_en_i,
    input  logic      line_end_i,
    input  logic      result_dv_i,
    output tap_ctl_t  tap_ctl_o,
    output logic      line_end_flag_o
);

    logic                 dv_q;
    logic                 restart;
    logic [K_W-1:0]       cnt_k_q;
    logic [DEPTH_W-1:0]   cog_q;
    logic [DEPTH_W-1:0]   wog_q;
    logic [K_W-1:0]       cnt_k;
    logic [DEPTH_W-1:0]   cog;
    logic [DEPTH_W-1:0]   wog;
    logic                 k_last;
    logic                 cog_last;
    logic                 wog_last;
    logic [2*DEPTH_W-1:0] addr_full;
    logic                 compute_en_q;
    logic                 first_row_q;

    // --------------------------------------------------
    // counters
    // --------------------------------------------------

    // first beat after a gap counts as position zero
    assign restart = result_dv_i & ~dv_q;

    assign cnt_k = restart ? '0 : cnt_k_q;
    assign cog   = restart ? '0 : cog_q;
    assign wog   = restart ? '0 : wog_q;

    assign k_last   = (cnt_k == cfg_i.kx - K_W'(1));
    assign cog_last = (cog == cfg_i.co_group - DEPTH_W'(1));
    assign wog_last = (wog == cfg_i.wo_group - DEPTH_W'(1));

    always_ff @(posedge I_clk)
    begin
        if (reset_i)
        begin
            dv_q    <= 1'b0;
            cnt_k_q <= '0;
            cog_q   <= '0;
            wog_q   <= '0;
        end
        else
        begin
            dv_q <= result_dv_i;
            if (result_dv_i)
            begin
                if (k_last)
                begin
                    cnt_k_q <= '0;
                    if (cog_last)
                    begin
                        cog_q <= '0;
                        wog_q <= wog_last ? '0 : wog + DEPTH_W'(1);
                    end
                    else
                    begin
                        cog_q <= cog + DEPTH_W'(1);
                        wog_q <= wog;
                    end
                end
                else
                begin
                    cnt_k_q <= cnt_k + K_W'(1);
                    cog_q   <= cog;
                    wog_q   <= wog;
                end
            end
        end
    end

    // wo group * co_group + co group
    assign addr_full = wog * cfg_i.co_group + cog;

    // group_end also held high in gaps so the next beat starts a fresh sum
    always_comb
    begin
        tap_ctl_o.group_end = k_last | ~result_dv_i;
        tap_ctl_o.rd_en     = k_last & result_dv_i;
        tap_ctl_o.addr      = addr_full[DEPTH_W-1:0];
        tap_ctl_o.first_row = first_row_q;
    end

    // --------------------------------------------------
    // first row and line end
    // --------------------------------------------------

    always_ff @(posedge I_clk)
    begin
        if (reset_i)
        begin
            compute_en_q    <= 1'b0;
            first_row_q     <= 1'b0;
            line_end_flag_o <= 1'b0;
        end
        else
        begin
            compute_en_q    <= compute_en_i;
            line_end_flag_o <= result_dv_i & k_last & cog_last & wog_last;
            if (line_end_flag_o)
                first_row_q <= 1'b0;
            else if ((compute_en_i & ~compute_en_q) | line_end_i)
                first_row_q <= 1'b1;
        end
    end

endmodule

//--- verilog/kx_accumulator.sv
`timescale 1ns/1ps

module kx_accumulator
    import conv_acc_pkg::*;
(
    input  logic  I_clk,
    input  logic  reset_i,
    input  logic  result_dv_i,
    input  beat_t result_i,
    input  logic  group_end_i,
    output macc_t group_sum_o
);

    macc_t ext;
    macc_t sum_q;
    logic  reload_q;

    function automatic logic [ACC_W-1:0] sext(input logic [PROD_W-1:0] p);
        return {{(ACC_W-PROD_W){p[PROD_W-1]}}, p};
    endfunction

    // sign extension of every product
    always_comb
    begin
        for (int i = 0; i < PIX*LANES; i++)
        begin
            ext[i].hi = sext(result_i[i].hi);
            ext[i].lo = sext(result_i[i].lo);
        end
    end

    // next beat opens a new group
    always_ff @(posedge I_clk)
    begin
        if (reset_i)
            reload_q <= 1'b1;
        else
            reload_q <= group_end_i;
    end

    // running half sums, wrap at ACC_W
    always_ff @(posedge I_clk)
    begin
        if (result_dv_i)
        begin
            for (int i = 0; i < PIX*LANES; i++)
            begin
                sum_q[i].hi <= reload_q ? ext[i].hi : sum_q[i].hi + ext[i].hi;
                sum_q[i].lo <= reload_q ? ext[i].lo : sum_q[i].lo + ext[i].lo;
            end
        end
    end

    assign group_sum_o = sum_q;

endmodule

//--- verilog/obuf_accumulate.sv
`timescale 1ns/1ps

module obuf_accumulate
    import conv_acc_pkg::*;
(
    input  logic     I_clk,
    input  logic     reset_i,
    input  tap_ctl_t tap_ctl_i,
    input  macc_t    group_sum_i,
    output logic     data_dv_o,
    output macc_t    macc_data_o
);

    macc_t              mem [OBUF_DEPTH];
    macc_t              rd_data_q;
    macc_t              wr_data;
    logic               wr_en_q;
    logic               first_row_q;
    logic [DEPTH_W-1:0] wr_addr_q;

    // --------------------------------------------------
    // read side
    // --------------------------------------------------

    // registered read, valid one cycle after the group's last beat
    always_ff @(posedge I_clk)
    begin
        if (tap_ctl_i.rd_en)
            rd_data_q <= mem[tap_ctl_i.addr];
    end

    // write address follows the read by one cycle
    always_ff @(posedge I_clk)
    begin
        if (tap_ctl_i.rd_en)
            wr_addr_q <= tap_ctl_i.addr;
    end

    always_ff @(posedge I_clk)
    begin
        if (reset_i)
        begin
            wr_en_q     <= 1'b0;
            first_row_q <= 1'b0;
        end
        else
        begin
            wr_en_q     <= tap_ctl_i.rd_en;
            first_row_q <= tap_ctl_i.first_row;
        end
    end

    // --------------------------------------------------
    // write side
    // --------------------------------------------------

    // first kernel row overwrites, later rows add halfwise
    always_comb
    begin
        for (int i = 0; i < PIX*LANES; i++)
        begin
            if (first_row_q)
            begin
                wr_data[i] = group_sum_i[i];
            end
            else
            begin
                wr_data[i].hi = group_sum_i[i].hi + rd_data_q[i].hi;
                wr_data[i].lo = group_sum_i[i].lo + rd_data_q[i].lo;
            end
        end
    end

    always_ff @(posedge I_clk)
    begin
        if (wr_en_q)
            mem[wr_addr_q] <= wr_data;
    end

    // result word, held until the next update
    always_ff @(posedge I_clk)
    begin
        if (wr_en_q)
            macc_data_o <= wr_data;
    end

    always_ff @(posedge I_clk)
    begin
        if (reset_i)
            data_dv_o <= 1'b0;
        else
            data_dv_o <= wr_en_q;
    end

endmodule

//--- verilog/conv_acc_top.sv
`timescale 1ns/1ps

module conv_acc_top
    import conv_acc_pkg::*;
(
    input  logic      I_clk,
    input  logic      reset_i,

    // layer shape and line control
    input  conv_cfg_t cfg_i,
    input  logic      compute_en_i,
    input  logic      line_end_i,

    // product beats from the multiplier array
    input  logic      result_dv_i,
    input  beat_t     result_i,

    // updated buffer words
    output logic      data_dv_o,
    output macc_t     macc_data_o,
    output logic      line_end_flag_o
);

    tap_ctl_t tap_ctl;
    macc_t    group_sum;

    // --------------------------------------------------
    // tap, channel-group and width-group counting
    // --------------------------------------------------

    tap_counter i_tap_counter (
        .I_clk           (I_clk),
        .reset_i         (reset_i),
        .cfg_i           (cfg_i),
        .compute_en_i    (compute_en_i),
        .line_end_i      (line_end_i),
        .result_dv_i     (result_dv_i),
        .tap_ctl_o       (tap_ctl),
        .line_end_flag_o (line_end_flag_o)
    );

    // --------------------------------------------------
    // horizontal sum over kx beats
    // --------------------------------------------------

    kx_accumulator i_kx_accumulator (
        .I_clk       (I_clk),
        .reset_i     (reset_i),
        .result_dv_i (result_dv_i),
        .result_i    (result_i),
        .group_end_i (tap_ctl.group_end),
        .group_sum_o (group_sum)
    );

    // --------------------------------------------------
    // vertical sum in the output buffer
    // --------------------------------------------------

    obuf_accumulate i_obuf_accumulate (
        .I_clk       (I_clk),
        .reset_i     (reset_i),
        .tap_ctl_i   (tap_ctl),
        .group_sum_i (group_sum),
        .data_dv_o   (data_dv_o),
        .macc_data_o (macc_data_o)
    );

endmodule

//--- sim/conv_acc_asserts.sv
`timescale 1ns/1ps

module conv_acc_asserts
    import conv_acc_pkg::*;
(
    input logic      I_clk,
    input logic      reset_i,
    input conv_cfg_t cfg_i,
    input logic      result_dv_i,
    input logic      data_dv_i,
    input logic      line_end_flag_i
);

    int unsigned fail_count = 0;

    logic dv_q;
    logic seen_beat_q;
    int   tap_q;
    int   grp_q;
    int   tap;
    int   grp;
    int   row_groups;
    logic grp_last;
    logic row_last;

    // --------------------------------------------------
    // beat and group position in the row
    // --------------------------------------------------

    // a gap restarts both positions
    assign tap = (result_dv_i && !dv_q) ? 0 : tap_q;
    assign grp = (result_dv_i && !dv_q) ? 0 : grp_q;

    assign row_groups = int'(cfg_i.co_group) * int'(cfg_i.wo_group);
    assign grp_last   = result_dv_i && (tap == int'(cfg_i.kx) - 1);
    assign row_last   = grp_last && (grp == row_groups - 1);

    always_ff @(posedge I_clk)
    begin
        if (reset_i)
        begin
            dv_q        <= 1'b0;
            seen_beat_q <= 1'b0;
            tap_q       <= 0;
            grp_q       <= 0;
        end
        else
        begin
            dv_q <= result_dv_i;
            if (result_dv_i)
            begin
                seen_beat_q <= 1'b1;
                tap_q       <= grp_last ? 0 : tap + 1;
                grp_q       <= row_last ? 0 : (grp_last ? grp + 1 : grp);
            end
        end
    end

    // --------------------------------------------------
    // output timing
    // --------------------------------------------------

    a_quiet_before_beats: assert property (@(posedge I_clk) disable iff (reset_i)
        !seen_beat_q |-> !data_dv_i && !line_end_flag_i)
        else begin $error("output strobe before any input beat"); fail_count++; end

    a_dv_after_group: assert property (@(posedge I_clk) disable iff (reset_i)
        grp_last |-> ##2 data_dv_i)
        else begin $error("data_dv missing two cycles after a group"); fail_count++; end

    a_dv_only_after_group: assert property (@(posedge I_clk) disable iff (reset_i)
        data_dv_i |-> $past(grp_last, 2))
        else begin $error("data_dv without a group two cycles earlier"); fail_count++; end

    a_flag_after_row: assert property (@(posedge I_clk) disable iff (reset_i)
        row_last |=> line_end_flag_i)
        else begin $error("line end flag missing after last group"); fail_count++; end

    a_flag_only_after_row: assert property (@(posedge I_clk) disable iff (reset_i)
        line_end_flag_i |-> $past(row_last))
        else begin $error("line end flag without a last group"); fail_count++; end

    a_flag_one_cycle: assert property (@(posedge I_clk) disable iff (reset_i)
        line_end_flag_i |=> !line_end_flag_i)
        else begin $error("line end flag wider than one cycle"); fail_count++; end

endmodule

//--- sim/conv_acc_tb.sv
`timescale 1ns/1ps

module conv_acc_tb;
    import conv_acc_pkg::*;

    // --------------------------------------------------
    // run shape
    // --------------------------------------------------

    localparam int RESET_CYC  = 16;
    localparam int SETUP_CYC  = 4;
    localparam int LINES      = 2;
    localparam int ROWS       = 3;
    localparam int LINE_CYC   = 3;
    localparam int PART_BEATS = 1;
    localparam int GAP_CYC    = 3;
    localparam int TAIL_CYC   = 4;

    function automatic int config_cycles(input int kx, input int co, input int wo);
        return SETUP_CYC + LINES * (LINE_CYC + ROWS * kx * co * wo + PART_BEATS + GAP_CYC
                                    + TAIL_CYC);
    endfunction

    localparam int STIM_CYC = RESET_CYC + config_cycles(3, 2, 2) + config_cycles(2, 3, 1);
    localparam int MAX_CYC  = 2 * STIM_CYC + 100;

    logic      I_clk;
    logic      reset_i;
    conv_cfg_t cfg_i;
    logic      compute_en_i;
    logic      line_end_i;
    logic      result_dv_i;
    beat_t     result_i;
    logic      data_dv_o;
    macc_t     macc_data_o;
    logic      line_end_flag_o;

    // reference buffer and the words still owed by the DUT
    macc_t model_mem [OBUF_DEPTH];
    macc_t expect_q [$];
    int    seed        = 32'hd73d_59cc;
    int    cycle_cnt   = 0;
    int    words_seen  = 0;

    initial I_clk = 1'b0;
    always #5 I_clk = ~I_clk;

    conv_acc_top i_conv_acc_top (
        .I_clk           (I_clk),
        .reset_i         (reset_i),
        .cfg_i           (cfg_i),
        .compute_en_i    (compute_en_i),
        .line_end_i      (line_end_i),
        .result_dv_i     (result_dv_i),
        .result_i        (result_i),
        .data_dv_o       (data_dv_o),
        .macc_data_o     (macc_data_o),
        .line_end_flag_o (line_end_flag_o)
    );

    bind conv_acc_top conv_acc_asserts i_conv_acc_asserts (
        .I_clk           (I_clk),
        .reset_i         (reset_i),
        .cfg_i           (cfg_i),
        .result_dv_i     (result_dv_i),
        .data_dv_i       (data_dv_o),
        .line_end_flag_i (line_end_flag_o)
    );

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------

    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(posedge I_clk);
            #1;
            result_dv_i = 1'b0;
            line_end_i  = 1'b0;
        end
    endtask

    task automatic pulse_line_end();
        @(posedge I_clk);
        #1;
        result_dv_i = 1'b0;
        line_end_i  = 1'b1;
    endtask

    // kx beats of one group, then the model update of its buffer word
    task automatic run_group(input int kx, input int addr, input bit first_row);
        beat_t beat;
        macc_t sum;
        macc_t word;
        int    r;
        sum = '0;
        for (int k = 0; k < kx; k++)
        begin
            for (int i = 0; i < PIX*LANES; i++)
            begin
                r = $random(seed);
                beat[i].hi = r[PROD_W-1:0];
                r = $random(seed);
                beat[i].lo = r[PROD_W-1:0];
                sum[i].hi = sum[i].hi + ACC_W'(int'($signed(beat[i].hi)));
                sum[i].lo = sum[i].lo + ACC_W'(int'($signed(beat[i].lo)));
            end
            @(posedge I_clk);
            #1;
            line_end_i  = 1'b0;
            result_dv_i = 1'b1;
            result_i    = beat;
        end
        for (int i = 0; i < PIX*LANES; i++)
        begin
            if (first_row)
            begin
                word[i] = sum[i];
            end
            else
            begin
                word[i].hi = model_mem[addr][i].hi + sum[i].hi;
                word[i].lo = model_mem[addr][i].lo + sum[i].lo;
            end
        end
        model_mem[addr] = word;
        expect_q.push_back(word);
    endtask

    // beats of an unfinished group, dropped at the next gap
    task automatic run_partial(input int n);
        beat_t beat;
        int    r;
        for (int k = 0; k < n; k++)
        begin
            for (int i = 0; i < PIX*LANES; i++)
            begin
                r = $random(seed);
                beat[i].hi = r[PROD_W-1:0];
                r = $random(seed);
                beat[i].lo = r[PROD_W-1:0];
            end
            @(posedge I_clk);
            #1;
            line_end_i  = 1'b0;
            result_dv_i = 1'b1;
            result_i    = beat;
        end
    endtask

    // rows start at group 0, so the address is the group index in the row
    task automatic run_row(input int kx, input int co, input int wo, input bit first_row);
        for (int g = 0; g < co * wo; g++)
            run_group(kx, g, first_row);
    endtask

    task automatic run_config(input int kx, input int co, input int wo);
        @(posedge I_clk);
        #1;
        cfg_i.kx       = K_W'(kx);
        cfg_i.co_group = DEPTH_W'(co);
        cfg_i.wo_group = DEPTH_W'(wo);
        compute_en_i   = 1'b0;
        idle_cycles(1);
        @(posedge I_clk);
        #1;
        compute_en_i = 1'b1;
        idle_cycles(1);
        for (int line = 0; line < LINES; line++)
        begin
            if (line > 0)
            begin
                pulse_line_end();
                idle_cycles(2);
            end
            for (int row = 0; row < ROWS; row++)
            begin
                run_row(kx, co, wo, row == 0);
                // unfinished group, then a short gap that restarts the counters
                if (row == 0)
                begin
                    run_partial(PART_BEATS);
                    idle_cycles(GAP_CYC);
                end
            end
            idle_cycles(TAIL_CYC);
        end
    endtask

    // --------------------------------------------------
    // checking
    // --------------------------------------------------

    task automatic check_result();
        macc_t want;
        if (expect_q.size() == 0)
        begin
            stop_run("result strobe arrived while the model had no group pending");
        end
        else
        begin
            want = expect_q.pop_front();
            words_seen++;
            assert (macc_data_o == want)
            else
                stop_run($sformatf("[FAIL] %0t: word %0d is %h, expected %h",
                                   $time, words_seen, macc_data_o, want));
        end
    endtask

    always @(negedge I_clk)
    begin
        if (!reset_i && data_dv_o)
            check_result();
    end

    always @(negedge I_clk)
    begin
        if (i_conv_acc_top.i_conv_acc_asserts.fail_count != 0)
            stop_run("a protocol assertion in conv_acc_asserts failed");
    end

    always @(posedge I_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > MAX_CYC)
            stop_run($sformatf("timeout: run did not finish within %0d cycles", MAX_CYC));
    end

    initial
    begin
        reset_i      = 1'b1;
        cfg_i        = '0;
        compute_en_i = 1'b0;
        line_end_i   = 1'b0;
        result_dv_i  = 1'b0;
        result_i     = '0;
        repeat (RESET_CYC) @(posedge I_clk);
        #1;
        reset_i = 1'b0;

        run_config(3, 2, 2);
        run_config(2, 3, 1);

        while (expect_q.size() != 0)
            @(posedge I_clk);
        idle_cycles(4);

        if (i_conv_acc_top.i_conv_acc_asserts.fail_count != 0)
        begin
            stop_run("protocol assertions failed during the run");
        end
        else
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- flist.f
verilog/conv_acc_pkg.sv
verilog/tap_counter.sv
verilog/kx_accumulator.sv
verilog/obuf_accumulate.sv
verilog/conv_acc_top.sv
sim/conv_acc_asserts.sv
sim/conv_acc_tb.sv

//--- Bender.yml
package:
  name: conv_acc

sources:
  - files:
      - verilog/conv_acc_pkg.sv
      - verilog/tap_counter.sv
      - verilog/kx_accumulator.sv
      - verilog/obuf_accumulate.sv
      - verilog/conv_acc_top.sv
  - target: simulation
    files:
      - sim/conv_acc_asserts.sv
      - sim/conv_acc_tb.sv
